// ==== uart_pkg.sv ====
package uart_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Serial framing, 8N1 at 115200 baud from a 50 MHz clock.
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned data_bits  = 8;  // Payload bits per frame.
  localparam int unsigned baud_cnt_w = 9;  // Width of the baud counters.
  localparam int unsigned bit_cnt_w  = 4;  // Width of the bit counters.

  // 50_000_000 / 115_200, rounded.
  localparam logic [baud_cnt_w-1:0] clks_per_bit = 9'd434;

  // Start edge to middle of the start bit.
  localparam logic [baud_cnt_w-1:0] half_bit = 9'd217;

  // Start bit, eight data bits and one stop bit.
  localparam logic [bit_cnt_w-1:0] frame_bits = 4'd10;

  ////////////////////////////////////////////////////////////////////////////
  // Payload.
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [data_bits-1:0] uart_byte_t;  // One byte on the wire.

endpackage

// ==== cmd_pkg.sv ====
package cmd_pkg;

  import uart_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Command and response formats.
  ////////////////////////////////////////////////////////////////////////////

  // Opcode goes out first, operand second.
  typedef struct packed {
    uart_byte_t opcode;   // High byte.
    uart_byte_t operand;  // Low byte.
  } cmd_word_t;

  typedef uart_byte_t resp_t;  // Single byte reply from the robot.

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer states.
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    idle      = 2'd0,  // Waiting for snd_cmd.
    send_high = 2'd1,  // Opcode frame on the line.
    send_low  = 2'd2   // Operand frame on the line.
  } link_state_t;

endpackage

// ==== uart_tx.sv ====
module uart_tx import uart_pkg::*; (
  input  logic       clk,      // System clock.
  input  logic       rst_n,    // Asynchronous active low reset.
  input  logic       trmt,     // One-cycle strobe, loads tx_data.
  input  uart_byte_t tx_data,  // Byte to send, only looked at with trmt.
  output logic       tx,       // Serial line, idles high.
  output logic       tx_done   // Set after the stop bit, cleared by trmt.
);

  logic [data_bits:0]    shift_reg;  // Data bits then stop bit, LSB first.
  logic [baud_cnt_w-1:0] baud_cnt;   // Clocks into the current bit.
  logic [bit_cnt_w-1:0]  bit_cnt;    // Bit index, 0 is the start bit.
  logic                  busy;       // Frame in progress.
  logic                  bit_end;    // Last clock of a bit period.
  logic                  last_bit;   // Stop bit is the current bit.

  assign bit_end  = busy && (baud_cnt == clks_per_bit - 1'b1);
  assign last_bit = (bit_cnt == frame_bits - 1'b1);

  ////////////////////////////////////////////////////////////////////////////
  // Shift register.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (trmt)
      shift_reg <= {1'b1, tx_data};                // Stop bit above the data.
    else if (bit_end)
      shift_reg <= {1'b1, shift_reg[data_bits:1]}; // Fill with idle level.
  end

  ////////////////////////////////////////////////////////////////////////////
  // Baud and bit counters, line driver.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;             // Line idles high.
      tx_done  <= 1'b0;
    end else if (trmt) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b0;             // Start bit goes out right away.
      tx_done  <= 1'b0;
    end else if (busy) begin
      if (bit_end) begin
        baud_cnt <= '0;
        if (last_bit) begin
          busy    <= 1'b0;          // Stop bit done, tx already high.
          tx_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          tx      <= shift_reg[0];  // Next data bit, or the stop bit.
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== uart_rx.sv ====
module uart_rx import uart_pkg::*; (
  input  logic       clk,      // System clock.
  input  logic       rst_n,    // Asynchronous active low reset.
  input  logic       rx,       // Serial line in, asynchronous.
  output uart_byte_t rx_data,  // Last good byte.
  output logic       rx_rdy    // High from a good stop bit to the next start.
);

  logic                  rx_meta;     // First synchronizer stage.
  logic                  rx_sync;     // Second stage, safe to use.
  logic                  rx_prev;     // Delayed copy for edge detect.
  logic                  start_edge;  // Falling edge while idle.
  logic [baud_cnt_w-1:0] baud_cnt;    // Counts down to the next sample.
  logic [bit_cnt_w-1:0]  bit_cnt;     // Bit index, 0 is the start bit.
  logic                  busy;        // Frame in progress.
  logic                  sample;      // Middle of the current bit.
  logic                  data_bit;    // Sample belongs to the payload.
  logic                  stop_bit;    // Sample is the stop bit.
  uart_byte_t            shift_reg;   // Assembles the byte, LSB first.

  ////////////////////////////////////////////////////////////////////////////
  // Input synchronizer and start detect.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;  // Idle line level.
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = !busy && rx_prev && !rx_sync;
  assign sample     = busy && (baud_cnt == baud_cnt_w'(1));
  assign stop_bit   = sample && (bit_cnt == frame_bits - 1'b1);
  assign data_bit   = sample && (bit_cnt != '0) && !stop_bit;

  ////////////////////////////////////////////////////////////////////////////
  // Data shift register.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (data_bit)
      shift_reg <= {rx_sync, shift_reg[data_bits-1:1]};  // LSB arrives first.
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bit timing, stop check and output.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_rdy   <= 1'b0;
      rx_data  <= '0;
    end else if (start_edge) begin
      busy     <= 1'b1;
      baud_cnt <= half_bit;          // First sample lands mid start bit.
      bit_cnt  <= '0;
      rx_rdy   <= 1'b0;              // Old byte is no longer fresh.
    end else if (busy) begin
      if (sample) begin
        baud_cnt <= clks_per_bit;    // One full bit to the next sample.
        bit_cnt  <= bit_cnt + 1'b1;
        if ((bit_cnt == '0) && rx_sync)
          busy <= 1'b0;              // Glitch, not a real start bit.
        if (stop_bit) begin
          busy <= 1'b0;
          if (rx_sync) begin         // Framing error drops the byte.
            rx_rdy  <= 1'b1;
            rx_data <= shift_reg;
          end
        end
      end else begin
        baud_cnt <= baud_cnt - 1'b1;
      end
    end
  end

endmodule

// ==== cmd_link_ctrl.sv ====
module cmd_link_ctrl import uart_pkg::*, cmd_pkg::*; (
  input  logic       clk,      // System clock.
  input  logic       rst_n,    // Asynchronous active low reset.
  input  logic       snd_cmd,  // One-cycle request to send cmd.
  input  cmd_word_t  cmd,      // Command, only sampled with snd_cmd.
  input  logic       tx_done,  // Transmitter finished its frame.
  output logic       trmt,     // Load strobe to the transmitter.
  output uart_byte_t tx_data,  // Byte for the transmitter.
  output logic       cmd_snt   // Both frames out, held until next command.
);

  link_state_t state;        // Current sequencer state.
  link_state_t nxt_state;    // Next sequencer state.
  uart_byte_t  low_byte;     // Operand, held for the second frame.
  logic        accept;       // snd_cmd taken in idle.
  logic        set_cmd_snt;  // Operand frame has finished.

  ////////////////////////////////////////////////////////////////////////////
  // Operand capture and byte select.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept)
      low_byte <= cmd.operand;  // Caller may change cmd after the strobe.
  end

  // Opcode passes straight through in the accept cycle.
  assign tx_data = accept ? cmd.opcode : low_byte;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= idle;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state   = state;  // Hold by default.
    accept      = 1'b0;
    trmt        = 1'b0;
    set_cmd_snt = 1'b0;

    case (state)
      idle: begin
        if (snd_cmd) begin
          accept    = 1'b1;
          trmt      = 1'b1;       // Opcode frame starts next edge.
          nxt_state = send_high;
        end
      end
      send_high: begin
        if (tx_done) begin
          trmt      = 1'b1;       // Operand back to back, one clock gap.
          nxt_state = send_low;
        end
      end
      send_low: begin
        if (tx_done) begin
          set_cmd_snt = 1'b1;
          nxt_state   = idle;
        end
      end
      default: nxt_state = idle;  // Unused encoding.
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command sent flag.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      cmd_snt <= 1'b0;
    else if (accept)
      cmd_snt <= 1'b0;  // Only an accepted command knocks it down.
    else if (set_cmd_snt)
      cmd_snt <= 1'b1;
  end

endmodule

// ==== remote_comm.sv ====
module remote_comm import uart_pkg::*, cmd_pkg::*; (
  input  logic      clk,       // 50 MHz system clock.
  input  logic      rst_n,     // Asynchronous active low reset.
  input  logic      snd_cmd,   // Send request, one cycle.
  input  cmd_word_t cmd,       // Command to send.
  input  logic      rx,        // Serial line from the robot.
  output logic      tx,        // Serial line to the robot.
  output resp_t     resp,      // Last response byte.
  output logic      resp_rdy,  // Response valid.
  output logic      cmd_snt    // Command fully sent.
);

  logic       trmt;     // Sequencer load strobe.
  uart_byte_t tx_data;  // Byte from sequencer to transmitter.
  logic       tx_done;  // Transmitter frame complete.

  // Splits the command and paces the two frames.
  cmd_link_ctrl u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .snd_cmd (snd_cmd),
    .cmd     (cmd),
    .tx_done (tx_done),
    .trmt    (trmt),
    .tx_data (tx_data),
    .cmd_snt (cmd_snt)
  );

  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .trmt    (trmt),
    .tx_data (tx_data),
    .tx      (tx),
    .tx_done (tx_done)
  );

  // Responses go straight out.
  uart_rx u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_data (resp),
    .rx_rdy  (resp_rdy)
  );

endmodule

// ==== tb_remote_comm.sv ====
module tb_remote_comm import uart_pkg::*, cmd_pkg::*; ();

  localparam int num_entries = 8;  // Commands in the stimulus table.

  // Three frames per entry, plus half again as margin.
  localparam int timeout_cycles = num_entries * 3 * frame_bits * clks_per_bit * 3 / 2;

  logic      clk;       // 50 MHz model clock.
  logic      rst_n;     // Asynchronous active low reset.
  logic      snd_cmd;   // Send strobe into the DUT.
  cmd_word_t cmd;       // Command word into the DUT.
  logic      rx;        // Line from the robot model.
  logic      tx;        // Line to the robot model.
  resp_t     resp;      // Response byte out of the DUT.
  logic      resp_rdy;  // Response valid.
  logic      cmd_snt;   // Command fully sent.

  cmd_word_t   tbl_cmd  [num_entries];  // Command to send.
  resp_t       tbl_resp [num_entries];  // Reply the robot returns.
  int          tbl_poke [num_entries];  // Cycles to a stray snd_cmd, 0 for none.
  logic [31:0] lcg_state;               // Random state.
  int          cycle_cnt = 0;           // Cycles since start.

  remote_comm uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .snd_cmd  (snd_cmd),
    .cmd      (cmd),
    .rx       (rx),
    .tx       (tx),
    .resp     (resp),
    .resp_rdy (resp_rdy),
    .cmd_snt  (cmd_snt)
  );

  always #20 clk = ~clk;  // 40 unit period.

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Run did not finish within %0d cycles.", timeout_cycles);
      stop_on_error();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error handling and compare tasks.
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("TB FAILED");
    $fatal(1, "Stopping at the first error.");
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_byte(input string name, input uart_byte_t actual,
                            input uart_byte_t expected);
    if (actual !== expected) begin
      $display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_word(input string name, input cmd_word_t actual,
                            input cmd_word_t expected);
    if (actual !== expected) begin
      $display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
      stop_on_error();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table and random values.
  ////////////////////////////////////////////////////////////////////////////

  function automatic cmd_word_t random_cmd();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG.
    return lcg_state[31:16];                                // Upper bits are better mixed.
  endfunction

  task automatic set_entry(input int idx, input cmd_word_t c, input resp_t r, input int poke);
    tbl_cmd[idx]  = c;
    tbl_resp[idx] = r;
    tbl_poke[idx] = poke;
  endtask

  task automatic load_table();
    cmd_word_t extra;
    set_entry(0, 16'h1a05, 8'h80, 0);
    set_entry(1, 16'h0000, 8'hff, 0);     // All zero payload.
    set_entry(2, 16'hffff, 8'h00, 2000);  // Stray strobe in the opcode frame.
    set_entry(3, 16'ha55a, 8'h3c, 0);
    set_entry(4, 16'h8001, 8'h5a, 0);
    set_entry(5, 16'h7e81, 8'hc3, 6500);  // Stray strobe in the operand frame.
    set_entry(6, 16'h2200, 8'h01, 0);
    set_entry(7, 16'hd300, 8'ha7, 0);
    extra = random_cmd();
    tbl_cmd[6].operand = extra.operand;   // Random operands.
    extra = random_cmd();
    tbl_cmd[7].operand = extra.operand;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Serial line model.
  ////////////////////////////////////////////////////////////////////////////

  // Samples tx mid-bit on falling clock edges, LSB first.
  task automatic capture_frame(output uart_byte_t data);
    int waited;
    int i;
    waited = 0;
    @(negedge clk);
    while (tx !== 1'b0) begin
      if (waited >= 2 * clks_per_bit) begin
        $display("No start bit seen on tx within two bit periods.");
        stop_on_error();
      end
      @(negedge clk);
      waited++;
    end
    repeat (half_bit) @(negedge clk);
    check_bit("tx start bit", tx, 1'b0);
    for (i = 0; i < data_bits; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      data[i] = tx;
      check_bit("cmd_snt", cmd_snt, 1'b0);  // Low for the whole transfer.
    end
    repeat (clks_per_bit) @(negedge clk);
    if (tx !== 1'b1) begin
      $display("Stop bit on tx was low.");
      stop_on_error();
    end
    check_bit("cmd_snt", cmd_snt, 1'b0);
  endtask

  // Drives one 8N1 frame on rx, called and returning just after a rising edge.
  task automatic send_frame(input uart_byte_t data, input logic stop_level);
    logic [9:0] bits;
    int         i;
    bits = {stop_level, data, 1'b0};
    for (i = 0; i < frame_bits; i++) begin
      rx = bits[i];
      repeat (clks_per_bit) @(posedge clk);
      #2;
      if (i == 0)
        check_bit("resp_rdy", resp_rdy, 1'b0);  // Cleared by the start bit.
    end
    rx = 1'b1;
  endtask

  // Second strobe while the link is busy, must be ignored.
  task automatic pulse_while_busy(input int delay);
    if (delay > 0) begin
      repeat (delay) @(posedge clk);
      #2;
      snd_cmd = 1'b1;
      cmd     = random_cmd();
      @(posedge clk);
      #2;
      snd_cmd = 1'b0;
    end
  endtask

  task automatic wait_cmd_snt();
    int waited;
    waited = 0;
    while ((cmd_snt !== 1'b1) && (waited < 5 * clks_per_bit / 2)) begin
      @(negedge clk);
      waited++;
    end
    check_bit("cmd_snt", cmd_snt, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence.
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    cmd_word_t  got;
    uart_byte_t hi_byte;
    uart_byte_t lo_byte;
    resp_t      last_resp;
    int         i;
    clk       = 1'b0;
    rst_n     = 1'b0;
    snd_cmd   = 1'b0;
    cmd       = '0;
    rx        = 1'b1;  // Idle line.
    lcg_state = 32'hc50f_d94b;
    load_table();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    check_bit("tx", tx, 1'b1);
    check_bit("cmd_snt", cmd_snt, 1'b0);
    check_bit("resp_rdy", resp_rdy, 1'b0);
    check_byte("resp", resp, 8'h00);

    for (i = 0; i < num_entries; i++) begin
      if (i > 0)
        check_bit("cmd_snt", cmd_snt, 1'b1);  // Held since the last command.
      snd_cmd = 1'b1;
      cmd     = tbl_cmd[i];
      @(posedge clk);
      #2;
      snd_cmd = 1'b0;
      cmd     = random_cmd();  // Both bytes must already be captured.
      check_bit("cmd_snt", cmd_snt, 1'b0);
      fork
        begin
          capture_frame(hi_byte);
          capture_frame(lo_byte);
        end
        pulse_while_busy(tbl_poke[i]);
      join
      got.opcode  = hi_byte;
      got.operand = lo_byte;
      check_word("tx command", got, tbl_cmd[i]);
      wait_cmd_snt();
      @(posedge clk);
      #2;
      send_frame(tbl_resp[i], 1'b1);
      check_bit("resp_rdy", resp_rdy, 1'b1);
      check_byte("resp", resp, tbl_resp[i]);
      check_bit("cmd_snt", cmd_snt, 1'b1);
    end

    // Framing error, the byte is dropped.
    last_resp = resp;
    send_frame(~last_resp, 1'b0);
    repeat (4) @(posedge clk);
    #2;
    check_bit("resp_rdy", resp_rdy, 1'b0);
    check_byte("resp", resp, last_resp);
    check_bit("cmd_snt", cmd_snt, 1'b1);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== flist.f ====
uart_pkg.sv
cmd_pkg.sv
uart_tx.sv
uart_rx.sv
cmd_link_ctrl.sv
remote_comm.sv
tb_remote_comm.sv

// ==== Bender.yml ====
package:
  name: remote_comm

sources:
  - uart_pkg.sv
  - cmd_pkg.sv
  - uart_tx.sv
  - uart_rx.sv
  - cmd_link_ctrl.sv
  - remote_comm.sv
  - target: simulation
    files:
      - tb_remote_comm.sv
